//--- source/rx_align_pkg.sv
`default_nettype none

package rx_align_pkg;

    //////////////////////////////////////////////////////////////////////
    // Receiver geometry
    //////////////////////////////////////////////////////////////////////
    localparam int LANES  = 8;
    localparam int WORD_W = 8;   // 1:8 DDR deserialization
    localparam int TAP_W  = 5;   // IDELAY count value width

    // Control loop timing, all in rxclk_div cycles
    localparam int STEP_CYCLES = 32;   // Settle time per delay step
    localparam int SLIP_WAIT   = 16;   // Bitslip takes a few cycles to show
    localparam int MAX_LOOPS   = 3;

    typedef logic [TAP_W-1:0]        tap_t;
    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [15:0]             bit_rate_t;   // Mbps as hex digits, eg 16'h0641
    typedef logic [LANES*WORD_W-1:0] lane_words_t;

    // Forwarded clock sampled 1:8 gives four ones then four zeros
    localparam word_t CLK_PATTERN = 8'hF0;

    //////////////////////////////////////////////////////////////////////
    // Status and state types
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic mmcm_ok;      // Clock locked and delays ready
        logic delay_done;   // Clock delay centered
        logic slip_done;    // Words aligned
    } lock_status_s;

    typedef enum logic [2:0] {
        SEARCH,
        CENTER,
        MOVE,
        RELEASE,
        LOCKED
    } search_state_e;

    typedef enum logic {CHECK, SLIP_WAIT_ST} slip_state_e;

    typedef enum logic [1:0] {PER_CLOCK, TWO_LANE, PER_LANE} data_format_e;

endpackage

`default_nettype wire

//--- source/bit_time_lut.sv
`timescale 1ns/10ps
`default_nettype none

module bit_time_lut (
    input  wire                          rxclk_div,
    input  wire                          rst_n,
    input  wire rx_align_pkg::bit_rate_t bit_rate,
    output rx_align_pkg::tap_t           bit_time
);
    import rx_align_pkg::*;

    tap_t taps;   // Taps in one bit period

    // Faster links need fewer taps to span one bit
    always_comb begin
        if      (bit_rate > 16'h1068) taps = 5'd12;
        else if (bit_rate > 16'h0986) taps = 5'd13;
        else if (bit_rate > 16'h0916) taps = 5'd14;
        else if (bit_rate > 16'h0855) taps = 5'd15;
        else if (bit_rate > 16'h0801) taps = 5'd16;
        else if (bit_rate > 16'h0754) taps = 5'd17;
        else if (bit_rate > 16'h0712) taps = 5'd18;
        else if (bit_rate > 16'h0675) taps = 5'd19;
        else if (bit_rate > 16'h0641) taps = 5'd20;
        else if (bit_rate > 16'h0611) taps = 5'd21;
        else if (bit_rate > 16'h0583) taps = 5'd22;
        else if (bit_rate > 16'h0557) taps = 5'd23;
        else if (bit_rate > 16'h0534) taps = 5'd24;
        else if (bit_rate > 16'h0513) taps = 5'd25;
        else if (bit_rate > 16'h0493) taps = 5'd26;
        else if (bit_rate > 16'h0475) taps = 5'd27;
        else if (bit_rate > 16'h0458) taps = 5'd28;
        else if (bit_rate > 16'h0442) taps = 5'd29;
        else if (bit_rate > 16'h0427) taps = 5'd30;
        else                          taps = 5'd31;   // Slowest rates saturate the line
    end

    always_ff @(posedge rxclk_div) begin
        if (!rst_n) begin
            bit_time <= 5'd31;
        end else begin
            bit_time <= taps;
        end
    end

endmodule

`default_nettype wire

//--- source/clk_delay_search.sv
`timescale 1ns/10ps
`default_nettype none

module clk_delay_search (
    input  wire                      rxclk_div,
    input  wire                      rst_n,
    input  wire                      mmcm_ok,
    input  wire rx_align_pkg::word_t clk_word,
    input  wire rx_align_pkg::tap_t  bit_time,
    output rx_align_pkg::tap_t       clk_tap,
    output logic                     serdes_rst,
    output logic                     search_done
);
    import rx_align_pkg::*;

    search_state_e                  state;
    logic                           hold;        // Clock or delays not ready
    logic                           warm_done;
    logic [$clog2(STEP_CYCLES)-1:0] step_cnt;
    logic                           step;
    logic [$clog2(MAX_LOOPS+1)-1:0] loop_cnt;
    word_t                          prev_word;
    logic                           word_changed;
    logic                           edge_flag;   // Edge seen since last step
    tap_t                           half_bit;
    tap_t                           target;
    logic                           move_up;

    assign half_bit = {1'b0, bit_time[TAP_W-1:1]};
    assign step     = warm_done && (step_cnt == STEP_CYCLES - 1);

    always_ff @(posedge rxclk_div) begin
        if (!rst_n) begin
            hold <= 1'b1;
        end else begin
            hold <= !mmcm_ok;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Edge detector on the deserialized clock word
    //////////////////////////////////////////////////////////////////////
    // A stable clock gives a constant word, so any change means the
    // sampling point sits on a transition
    always_ff @(posedge rxclk_div) begin
        prev_word    <= clk_word;
        word_changed <= (clk_word != prev_word) && (clk_word != '0) && (clk_word != '1);
    end

    // Stay on the short side of the edge to keep delay jitter low
    always_ff @(posedge rxclk_div) begin
        if (step && state == CENTER) begin
            if (clk_tap < half_bit) begin
                target  <= clk_tap + half_bit;
                move_up <= 1'b1;
            end else begin
                target  <= clk_tap - half_bit;
                move_up <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Search, center, release
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge rxclk_div) begin
        if (!rst_n || hold) begin
            state       <= SEARCH;
            warm_done   <= 1'b0;
            step_cnt    <= '0;
            loop_cnt    <= '0;
            edge_flag   <= 1'b0;
            clk_tap     <= bit_time;   // Start one bit period in
            serdes_rst  <= 1'b0;
            search_done <= 1'b0;
        end else begin
            if (step_cnt == STEP_CYCLES - 1) begin
                step_cnt  <= '0;
                warm_done <= 1'b1;   // First pass is warm-up only
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (step) begin
                edge_flag <= 1'b0;
            end else if (word_changed) begin
                edge_flag <= 1'b1;
            end

            if (step) begin
                case (state)
                    SEARCH: begin
                        // Give up after a few wraps and center where we stand
                        if (edge_flag || (loop_cnt == MAX_LOOPS && clk_tap == '0)) begin
                            state <= CENTER;
                        end else if (clk_tap != '0) begin
                            clk_tap <= clk_tap - 1'b1;
                        end else begin
                            clk_tap  <= bit_time;
                            loop_cnt <= loop_cnt + 1'b1;
                        end
                    end
                    CENTER: state <= MOVE;
                    MOVE: begin
                        // One tap per step so the MMCM keeps lock
                        if (clk_tap == target) begin
                            state <= RELEASE;
                        end else if (move_up) begin
                            clk_tap <= clk_tap + 1'b1;
                        end else begin
                            clk_tap <= clk_tap - 1'b1;
                        end
                    end
                    RELEASE: begin
                        serdes_rst <= 1'b1;
                        state      <= LOCKED;
                    end
                    LOCKED: begin
                        serdes_rst  <= 1'b0;
                        search_done <= 1'b1;
                    end
                    default: state <= SEARCH;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/bitslip_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bitslip_ctrl (
    input  wire                      rxclk_div,
    input  wire                      rst_n,
    input  wire                      search_done,
    input  wire rx_align_pkg::word_t clk_word,
    output logic                     bitslip,
    output logic                     slip_done
);
    import rx_align_pkg::*;

    slip_state_e                  state;
    logic                         enable;
    logic                         mismatch;   // Clock word off the framing pattern
    logic [$clog2(SLIP_WAIT)-1:0] wait_cnt;

    always_ff @(posedge rxclk_div) begin
        if (!rst_n || !search_done) begin
            state     <= SLIP_WAIT_ST;   // Let the deserializer settle first
            enable    <= 1'b0;
            mismatch  <= 1'b0;
            wait_cnt  <= '0;
            bitslip   <= 1'b0;
            slip_done <= 1'b0;
        end else begin
            enable <= 1'b1;
            if (enable) begin
                mismatch <= (clk_word != CLK_PATTERN);
                case (state)
                    CHECK: begin
                        if (!mismatch) begin
                            slip_done <= 1'b1;
                        end else if (!slip_done) begin
                            bitslip <= 1'b1;   // Rotate every lane by one bit
                            state   <= SLIP_WAIT_ST;
                        end
                    end
                    SLIP_WAIT_ST: begin
                        bitslip <= 1'b0;
                        if (wait_cnt == SLIP_WAIT - 1) begin
                            wait_cnt <= '0;
                            state    <= CHECK;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    default: state <= CHECK;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lane_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module lane_mapper #(
    parameter rx_align_pkg::data_format_e FORMAT = rx_align_pkg::TWO_LANE
) (
    input  wire                            rxclk_div,
    input  wire                            rst_n,
    input  wire rx_align_pkg::lane_words_t lane_words,
    output rx_align_pkg::lane_words_t      rx_data
);
    import rx_align_pkg::*;

    lane_words_t mapped;

    always_comb begin
        mapped = '0;
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < WORD_W; j++) begin
                case (FORMAT)
                    PER_CLOCK: mapped[LANES*j + i] = lane_words[WORD_W*i + j];
                    // Even lane on odd positions of the pair, odd lane on even ones
                    TWO_LANE: mapped[2*WORD_W*(i/2) + 2*j + 1 - (i%2)] = lane_words[WORD_W*i + j];
                    default: mapped[WORD_W*i + j] = lane_words[WORD_W*i + j];
                endcase
            end
        end
    end

    always_ff @(posedge rxclk_div) begin
        if (!rst_n) begin
            rx_data <= '0;
        end else begin
            rx_data <= mapped;
        end
    end

endmodule

`default_nettype wire

//--- source/rx_align_top.sv
`timescale 1ns/10ps
`default_nettype none

module rx_align_top (
    input  wire                            rxclk_div,
    input  wire                            rst_n,
    input  wire                            mmcm_locked,
    input  wire                            idelay_rdy,
    input  wire rx_align_pkg::bit_rate_t   bit_rate,
    input  wire rx_align_pkg::word_t       clk_word,     // Deserialized forwarded clock
    input  wire rx_align_pkg::lane_words_t lane_words,
    output rx_align_pkg::tap_t             bit_time,
    output rx_align_pkg::tap_t             clk_tap,
    output logic                           serdes_rst,
    output logic                           bitslip,
    output rx_align_pkg::lane_words_t      rx_data,
    output rx_align_pkg::lock_status_s     lock_status
);
    import rx_align_pkg::*;

    logic mmcm_ok;
    logic search_done;
    logic slip_done;

    assign mmcm_ok = mmcm_locked & idelay_rdy;

    bit_time_lut u_bit_time_lut (
        .rxclk_div (rxclk_div),
        .rst_n     (rst_n),
        .bit_rate  (bit_rate),
        .bit_time  (bit_time)
    );

    clk_delay_search u_clk_delay_search (
        .rxclk_div   (rxclk_div),
        .rst_n       (rst_n),
        .mmcm_ok     (mmcm_ok),
        .clk_word    (clk_word),
        .bit_time    (bit_time),
        .clk_tap     (clk_tap),
        .serdes_rst  (serdes_rst),
        .search_done (search_done)
    );

    bitslip_ctrl u_bitslip_ctrl (
        .rxclk_div   (rxclk_div),
        .rst_n       (rst_n),
        .search_done (search_done),
        .clk_word    (clk_word),
        .bitslip     (bitslip),
        .slip_done   (slip_done)
    );

    lane_mapper #(
        .FORMAT (TWO_LANE)
    ) u_lane_mapper (
        .rxclk_div  (rxclk_div),
        .rst_n      (rst_n),
        .lane_words (lane_words),
        .rx_data    (rx_data)
    );

    // Status drops at once when the MMCM loses lock
    assign lock_status = '{
        mmcm_ok:    mmcm_ok & mmcm_locked,
        delay_done: search_done & mmcm_locked,
        slip_done:  slip_done & mmcm_locked
    };

endmodule

`default_nettype wire

//--- tests/rx_align_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module rx_align_asserts (
    input wire                             rxclk_div,
    input wire                             rst_n,
    input wire                             bitslip,
    input wire                             serdes_rst,
    input wire                             search_done,
    input wire                             slip_done,
    input wire rx_align_pkg::lock_status_s lock_status
);
    int failures = 0;   // Count of assertion failures

    // One strobe per slip request
    a_single_slip: assert property (@(posedge rxclk_div) disable iff (!rst_n)
        bitslip |=> !bitslip)
    else begin
        failures++;
        $error("bitslip high on two consecutive cycles");
    end

    a_rst_vs_done: assert property (@(posedge rxclk_div) disable iff (!rst_n)
        !(serdes_rst && lock_status.delay_done))
    else begin
        failures++;
        $error("serdes_rst high while delay_done is set");
    end

    // Alignment only drops after the delay search restarted
    a_slip_done_held: assert property (@(posedge rxclk_div) disable iff (!rst_n)
        $fell(slip_done) |-> !search_done)
    else begin
        failures++;
        $error("slip_done fell during normal operation");
    end

endmodule

bind rx_align_top rx_align_asserts u_rx_align_asserts (
    .rxclk_div   (rxclk_div),
    .rst_n       (rst_n),
    .bitslip     (bitslip),
    .serdes_rst  (serdes_rst),
    .search_done (search_done),
    .slip_done   (slip_done),
    .lock_status (lock_status)
);

`default_nettype wire

//--- tests/rx_align_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rx_align_tb;
    import rx_align_pkg::*;

    localparam int        MAX_CYCLES   = 40000;
    localparam int        SEARCH_LIMIT = (MAX_LOOPS + 1) * 32 * STEP_CYCLES;
    localparam int        SLIP_LIMIT   = 8 * (SLIP_WAIT + 4) + 2 * SLIP_WAIT;
    localparam bit_rate_t CENTER_RATE  = 16'h0641;   // Rate for the centering runs
    localparam int        DELAY_BIT    = 1;
    localparam int        SLIP_BIT     = 0;

    // Rate thresholds, fastest first
    localparam bit_rate_t THRESH [19] = '{16'h1068, 16'h0986, 16'h0916, 16'h0855,
        16'h0801, 16'h0754, 16'h0712, 16'h0675, 16'h0641, 16'h0611, 16'h0583, 16'h0557,
        16'h0534, 16'h0513, 16'h0493, 16'h0475, 16'h0458, 16'h0442, 16'h0427};
    localparam tap_t EDGE_LIST [3] = '{5'd6, 5'd12, 5'd2};

    logic         rxclk_div   = 1'b0;
    logic         rst_n       = 1'b0;
    logic         mmcm_locked = 1'b0;
    logic         idelay_rdy  = 1'b1;
    bit_rate_t    bit_rate    = 16'h0641;
    word_t        clk_word    = 8'hF0;
    lane_words_t  lane_words  = '0;
    tap_t         bit_time;
    tap_t         clk_tap;
    logic         serdes_rst;
    logic         bitslip;
    lane_words_t  rx_data;
    lock_status_s lock_status;

    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_errors = 0;
    tap_t        edge_tap = 5'd6;   // Model clock edge position
    int          rot_now = 0;       // Model word rotation
    int          slips = 0;
    logic        rst_seen = 1'b0;
    logic        map_on = 1'b0;
    logic        map_armed = 1'b0;
    lane_words_t last_lanes = '0;

    rx_align_top uut (
        .rxclk_div   (rxclk_div),
        .rst_n       (rst_n),
        .mmcm_locked (mmcm_locked),
        .idelay_rdy  (idelay_rdy),
        .bit_rate    (bit_rate),
        .clk_word    (clk_word),
        .lane_words  (lane_words),
        .bit_time    (bit_time),
        .clk_tap     (clk_tap),
        .serdes_rst  (serdes_rst),
        .bitslip     (bitslip),
        .rx_data     (rx_data),
        .lock_status (lock_status)
    );

    initial begin
        forever #2 rxclk_div = ~rxclk_div;
    end

    always @(posedge rxclk_div) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run stopped", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////
    function automatic tap_t ref_bit_time(bit_rate_t rate);
        for (int i = 0; i < 19; i++) begin
            if (rate > THRESH[i]) return tap_t'(12 + i);
        end
        return 5'd31;
    endfunction

    function automatic tap_t ref_center(tap_t found, tap_t span);
        tap_t half;
        half = span >> 1;
        return (found < half) ? found + half : found - half;
    endfunction

    function automatic lane_words_t ref_lane_map(lane_words_t lanes);
        lane_words_t mapped;
        word_t       even_w;
        word_t       odd_w;
        for (int p = 0; p < LANES / 2; p++) begin
            even_w = lanes[(2*p)*WORD_W +: WORD_W];
            odd_w  = lanes[(2*p+1)*WORD_W +: WORD_W];
            for (int j = 0; j < WORD_W; j++) begin
                mapped[16*p + 2*j + 1] = even_w[j];
                mapped[16*p + 2*j]     = odd_w[j];
            end
        end
        return mapped;
    endfunction

    function automatic word_t rotate_left(word_t w, int n);
        return (w << n) | (w >> (WORD_W - n));
    endfunction

    // Deserializer model for the forwarded clock lane
    always @(posedge rxclk_div) begin
        #1;
        if (serdes_rst) rst_seen = 1'b1;
        if (bitslip) begin
            slips   = slips + 1;
            rot_now = (rot_now + WORD_W - 1) % WORD_W;   // One bit per slip
        end
        if (lock_status.delay_done) begin
            clk_word = rotate_left(CLK_PATTERN, rot_now);
        end else begin
            clk_word = (clk_tap > edge_tap) ? CLK_PATTERN : 8'hE1;
        end
    end

    // Lane mapping comparator, one cycle behind the inputs
    always @(negedge rxclk_div) begin
        if (map_armed) begin
            check_equal(rx_data, ref_lane_map(last_lanes), "rx_data lane mapping");
        end
        last_lanes = lane_words;
        map_armed  = map_on;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge rxclk_div);
        #1;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-28s %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic wait_status(input int idx, input int limit, input string what);
        int n;
        n = 0;
        while (!lock_status[idx] && n < limit) begin
            next_cycle();
            n++;
        end
        if (!lock_status[idx]) begin
            errors++;
            $display("%s did not rise within %0d cycles", what, limit);
        end
    endtask

    task automatic apply_rate(input bit_rate_t rate);
        bit_rate = rate;
        repeat (2) next_cycle();
        check_equal(bit_time, ref_bit_time(rate), $sformatf("bit_time for rate %h", rate));
    endtask

    task automatic align_run(input tap_t edge_e, input int rot);
        mmcm_locked = 1'b0;
        repeat (8) next_cycle();
        edge_tap    = edge_e;
        rot_now     = rot;
        slips       = 0;
        rst_seen    = 1'b0;
        mmcm_locked = 1'b1;
        wait_status(DELAY_BIT, SEARCH_LIMIT, "delay_done");
        check_equal(clk_tap, ref_center(edge_e, ref_bit_time(CENTER_RATE)),
                    "centered clock tap");
        check_equal(rst_seen, 1'b1, "serdes_rst pulse before delay_done");
        wait_status(SLIP_BIT, SLIP_LIMIT, "slip_done");
        check_equal(slips, rot, "bitslip pulse count");
        check_equal(clk_word, CLK_PATTERN, "clock word at slip_done");
        check_equal(lock_status, 3'b111, "lock_status when aligned");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int rot;
        void'($urandom(32'hcdb3));
        repeat (2) @(posedge rxclk_div);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_equal(serdes_rst, 1'b0, "serdes_rst after reset");
        check_equal(bitslip, 1'b0, "bitslip after reset");
        check_equal(lock_status, 3'b000, "lock_status after reset");
        check_equal(rx_data, '0, "rx_data after reset");
        end_test("reset_state");

        for (int i = 0; i < 25; i++) apply_rate($urandom_range(16'h1200, 16'h0300));
        for (int i = 0; i < 19; i++) begin
            apply_rate(THRESH[i]);
            apply_rate(THRESH[i] + 16'd1);
        end
        end_test("bit_time_table");
        apply_rate(CENTER_RATE);

        rot = 0;
        foreach (EDGE_LIST[k]) begin
            rot = $urandom_range(7, 0);
            align_run(EDGE_LIST[k], rot);
            end_test($sformatf("align edge %0d rot %0d", EDGE_LIST[k], rot));
        end

        map_on = 1'b1;
        repeat (20) begin
            lane_words = {$urandom, $urandom};
            next_cycle();
        end
        map_on = 1'b0;
        repeat (2) next_cycle();
        end_test("lane_mapping");

        mmcm_locked = 1'b0;
        repeat (2) next_cycle();
        check_equal(lock_status, 3'b000, "lock_status after loss of lock");
        align_run(EDGE_LIST[2], rot);   // Same edge and rotation as the last run
        end_test("loss_of_lock");

        errors = errors + uut.u_rx_align_asserts.failures;
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/rx_align_pkg.sv
source/bit_time_lut.sv
source/clk_delay_search.sv
source/bitslip_ctrl.sv
source/lane_mapper.sv
source/rx_align_top.sv
tests/rx_align_asserts.sv
tests/rx_align_tb.sv

//--- Bender.yml
package:
  name: rx_align

sources:
  - source/rx_align_pkg.sv
  - source/bit_time_lut.sv
  - source/clk_delay_search.sv
  - source/bitslip_ctrl.sv
  - source/lane_mapper.sv
  - source/rx_align_top.sv
  - target: test
    files:
      - tests/rx_align_asserts.sv
      - tests/rx_align_tb.sv
